// ==== uart_regs_pkg.sv ====
// Shared widths, register offsets, bit positions, ID value and control field struct
package uart_regs_pkg;

    // ------------------------------
    // Bus widths
    // ------------------------------
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;

    // ------------------------------
    // Register map
    // ------------------------------
    localparam addr_t ADDR_STAT   = 16'h000C;
    localparam addr_t ADDR_CTRL   = 16'h0010;
    localparam addr_t ADDR_LPMODE = 16'h0014;
    localparam addr_t ADDR_INSTAT = 16'h0020;
    localparam addr_t ADDR_ID     = 16'h0040;

    // Fixed identifier returned by ID
    localparam data_t ID_VALUE = 32'hCAFE0666;

    // Single-bit field positions
    localparam int CTRL_TXEN_BIT  = 4;
    localparam int CTRL_RXEN_BIT  = 5;
    localparam int CTRL_TXST_BIT  = 6;
    localparam int INSTAT_TX_BIT  = 0;
    localparam int INSTAT_RX_BIT  = 1;
    localparam int LPMODE_EN_BIT  = 31;
    localparam int STAT_BUSY_BIT  = 2;
    localparam int STAT_RXE_BIT   = 4;
    localparam int STAT_TXF_BIT   = 8;

    // Baud rate select, CTRL[1:0]
    typedef logic [1:0] baud_t;

    // Stored fields, 15 bits
    typedef struct packed {
        baud_t      baud;
        logic       txen;
        logic       rxen;
        logic [7:0] lpmode_div;
        logic       lpmode_en;
        logic       instat_tx;
        logic       instat_rx;
    } ctrl_fields_t;

endpackage

// ==== reg_bus_if.sv ====
// Internal register write and read bus with source and destination modports
interface reg_bus_if;
    import uart_regs_pkg::*;

    // Write group, one-cycle strobe with held address, data and strobes
    logic  wen;
    addr_t waddr;
    data_t wdata;
    strb_t wstrb;

    // Read group, data valid the cycle after ren and zero otherwise
    logic  ren;
    addr_t raddr;
    data_t rdata;

    // AXI write side
    modport wr_src (output wen, waddr, wdata, wstrb);

    // Register storage
    modport wr_dst (input wen, waddr, wdata, wstrb);

    // AXI read side
    modport rd_src (output ren, raddr, input rdata);

    // Read-out mux
    modport rd_dst (input ren, raddr, output rdata);

endinterface

// ==== axil_write_port.sv ====
// AXI4-Lite write address and data capture, write strobe and write response
module axil_write_port (
    input  logic                 clk,
    input  logic                 rst,
    // Write address channel
    input  uart_regs_pkg::addr_t awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    // Write data channel
    input  uart_regs_pkg::data_t wdata,
    input  uart_regs_pkg::strb_t wstrb,
    input  logic                 wvalid,
    output logic                 wready,
    // Write response channel, always OKAY
    output logic                 bvalid,
    input  logic                 bready,
    // Register bus
    reg_bus_if.wr_src            bus
);
    import uart_regs_pkg::*;

    // Channel holds
    logic aw_held;
    logic w_held;

    // Both channels stall while a response is pending
    assign awready = ~aw_held & ~bvalid;
    assign wready  = ~w_held & ~bvalid;

    // ------------------------------
    // Handshake control
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            bus.wen <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            // Strobe one cycle after both halves are held
            bus.wen <= aw_held & w_held & ~bus.wen;

            if (bus.wen) begin
                // Register updates at this edge, response goes out
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                bvalid  <= 1'b1;
            end else begin
                // Address and data in any order
                if (awvalid && awready) begin
                    aw_held <= 1'b1;
                end
                if (wvalid && wready) begin
                    w_held <= 1'b1;
                end
                if (bvalid && bready) begin
                    bvalid <= 1'b0;
                end
            end
        end
    end

    // ------------------------------
    // Payload capture
    // ------------------------------
    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            bus.waddr <= awaddr;
        end
        if (wvalid && wready) begin
            bus.wdata <= wdata;
            bus.wstrb <= wstrb;
        end
    end

endmodule

// ==== axil_read_port.sv ====
// AXI4-Lite read address capture, read strobe and read data return
module axil_read_port (
    input  logic                 clk,
    input  logic                 rst,
    // Read address channel
    input  uart_regs_pkg::addr_t araddr,
    input  logic                 arvalid,
    output logic                 arready,
    // Read data channel, always OKAY
    output uart_regs_pkg::data_t rdata,
    output logic                 rvalid,
    input  logic                 rready,
    // Register bus
    reg_bus_if.rd_src            bus
);
    import uart_regs_pkg::*;

    // Read in progress from address accept to data accept
    logic ar_held;
    // Decoder word lands on the bus this cycle
    logic rdata_due;

    assign arready = ~ar_held;

    // ------------------------------
    // Handshake control
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ar_held   <= 1'b0;
            bus.ren   <= 1'b0;
            rdata_due <= 1'b0;
            rvalid    <= 1'b0;
        end else begin
            // One strobe per accepted address
            bus.ren   <= arvalid & arready;
            rdata_due <= bus.ren;

            if (arvalid && arready) begin
                ar_held <= 1'b1;
            end else if (rvalid && rready) begin
                // Address channel frees after data accept
                ar_held <= 1'b0;
            end

            if (rdata_due) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // ------------------------------
    // Payload capture
    // ------------------------------
    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            bus.raddr <= araddr;
        end
        // Word held stable until rready
        if (rdata_due) begin
            rdata <= bus.rdata;
        end
    end

endmodule

// ==== uart_ctrl_regs.sv ====
// CTRL, LPMODE and INSTAT storage with byte-strobed bus writes and hardware updates
module uart_ctrl_regs (
    input  logic                        clk,
    input  logic                        rst,
    // Hardware overwrite of enables
    input  logic                        txen_set_en,
    input  logic                        txen_in,
    input  logic                        rxen_set_en,
    input  logic                        rxen_in,
    // Interrupt sources
    input  logic                        instat_tx_set,
    input  logic                        instat_rx_set,
    // Stored fields and start pulse
    output uart_regs_pkg::ctrl_fields_t fields,
    output logic                        ctrl_txst,
    // Register bus
    reg_bus_if.wr_dst                   bus
);
    import uart_regs_pkg::*;

    // Address decode
    logic ctrl_wen;
    logic lpmode_wen;
    logic instat_wen;

    assign ctrl_wen   = bus.wen && (bus.waddr == ADDR_CTRL);
    assign lpmode_wen = bus.wen && (bus.waddr == ADDR_LPMODE);
    assign instat_wen = bus.wen && (bus.waddr == ADDR_INSTAT);

    // ------------------------------
    // CTRL
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            fields.baud <= '0;
            fields.txen <= 1'b0;
            fields.rxen <= 1'b0;
            ctrl_txst   <= 1'b0;
        end else begin
            if (ctrl_wen && bus.wstrb[0]) begin
                fields.baud <= bus.wdata[1:0];
            end

            // Bus write has priority over hardware
            if (ctrl_wen) begin
                if (bus.wstrb[0]) begin
                    fields.txen <= bus.wdata[CTRL_TXEN_BIT];
                end
            end else if (txen_set_en) begin
                fields.txen <= txen_in;
            end

            if (ctrl_wen) begin
                if (bus.wstrb[0]) begin
                    fields.rxen <= bus.wdata[CTRL_RXEN_BIT];
                end
            end else if (rxen_set_en) begin
                fields.rxen <= rxen_in;
            end

            // TXST pulse that is never stored
            ctrl_txst <= ctrl_wen & bus.wstrb[0] & bus.wdata[CTRL_TXST_BIT];
        end
    end

    // ------------------------------
    // LPMODE
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            fields.lpmode_div <= '0;
            fields.lpmode_en  <= 1'b0;
        end else if (lpmode_wen) begin
            // DIV in lane 0
            if (bus.wstrb[0]) begin
                fields.lpmode_div <= bus.wdata[7:0];
            end
            // EN in lane 3
            if (bus.wstrb[LPMODE_EN_BIT / 8]) begin
                fields.lpmode_en <= bus.wdata[LPMODE_EN_BIT];
            end
        end
    end

    // ------------------------------
    // INSTAT where a set beats write-1-clear
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            fields.instat_tx <= 1'b0;
            fields.instat_rx <= 1'b0;
        end else begin
            if (instat_tx_set) begin
                fields.instat_tx <= 1'b1;
            end else if (instat_wen && bus.wstrb[0] && bus.wdata[INSTAT_TX_BIT]) begin
                fields.instat_tx <= 1'b0;
            end

            if (instat_rx_set) begin
                fields.instat_rx <= 1'b1;
            end else if (instat_wen && bus.wstrb[0] && bus.wdata[INSTAT_RX_BIT]) begin
                fields.instat_rx <= 1'b0;
            end
        end
    end

endmodule

// ==== uart_read_decoder.sv ====
// STAT sampling, ID constant and registered read-data multiplexer
module uart_read_decoder (
    input  logic                        clk,
    input  logic                        rst,
    // Status inputs
    input  logic                        stat_busy_en,
    input  logic                        stat_busy_in,
    input  logic                        stat_rxe_in,
    input  logic                        stat_txf_in,
    // Stored control fields
    input  uart_regs_pkg::ctrl_fields_t fields,
    // Register bus
    reg_bus_if.rd_dst                   bus
);
    import uart_regs_pkg::*;

    // STAT flops
    logic stat_busy;
    logic stat_rxe;
    logic stat_txf;

    // Assembled register words
    data_t stat_word;
    data_t ctrl_word;
    data_t lpmode_word;
    data_t instat_word;

    // ------------------------------
    // Status sampling
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            stat_busy <= 1'b0;
            stat_rxe  <= 1'b0;
            stat_txf  <= 1'b0;
        end else begin
            // BUSY only while enabled
            if (stat_busy_en) begin
                stat_busy <= stat_busy_in;
            end
            stat_rxe <= stat_rxe_in;
            stat_txf <= stat_txf_in;
        end
    end

    // ------------------------------
    // Word assembly
    // ------------------------------
    always_comb begin
        stat_word   = '0;
        ctrl_word   = '0;
        lpmode_word = '0;
        instat_word = '0;

        stat_word[STAT_BUSY_BIT] = stat_busy;
        stat_word[STAT_RXE_BIT]  = stat_rxe;
        stat_word[STAT_TXF_BIT]  = stat_txf;

        // TXST stays 0 on read
        ctrl_word[1:0]           = fields.baud;
        ctrl_word[CTRL_TXEN_BIT] = fields.txen;
        ctrl_word[CTRL_RXEN_BIT] = fields.rxen;

        lpmode_word[7:0]           = fields.lpmode_div;
        lpmode_word[LPMODE_EN_BIT] = fields.lpmode_en;

        instat_word[INSTAT_TX_BIT] = fields.instat_tx;
        instat_word[INSTAT_RX_BIT] = fields.instat_rx;
    end

    // Registered mux, zero outside the read slot
    always_ff @(posedge clk) begin
        if (rst || !bus.ren) begin
            bus.rdata <= '0;
        end else begin
            case (bus.raddr)
                ADDR_STAT:   bus.rdata <= stat_word;
                ADDR_CTRL:   bus.rdata <= ctrl_word;
                ADDR_LPMODE: bus.rdata <= lpmode_word;
                ADDR_INSTAT: bus.rdata <= instat_word;
                ADDR_ID:     bus.rdata <= ID_VALUE;
                // Unmapped
                default:     bus.rdata <= '0;
            endcase
        end
    end

endmodule

// ==== uart_regs_top.sv ====
// UART register block top level with AXI4-Lite and peripheral ports
module uart_regs_top (
    input  logic                 clk,
    input  logic                 rst,

    // AXI4-Lite write
    input  uart_regs_pkg::addr_t axil_awaddr,
    input  logic                 axil_awvalid,
    output logic                 axil_awready,
    input  uart_regs_pkg::data_t axil_wdata,
    input  uart_regs_pkg::strb_t axil_wstrb,
    input  logic                 axil_wvalid,
    output logic                 axil_wready,
    output logic                 axil_bvalid,
    input  logic                 axil_bready,

    // AXI4-Lite read
    input  uart_regs_pkg::addr_t axil_araddr,
    input  logic                 axil_arvalid,
    output logic                 axil_arready,
    output uart_regs_pkg::data_t axil_rdata,
    output logic                 axil_rvalid,
    input  logic                 axil_rready,

    // Status
    input  logic                 stat_busy_en,
    input  logic                 stat_busy_in,
    input  logic                 stat_rxe_in,
    input  logic                 stat_txf_in,

    // Hardware enable updates
    input  logic                 ctrl_txen_en,
    input  logic                 ctrl_txen_in,
    input  logic                 ctrl_rxen_en,
    input  logic                 ctrl_rxen_in,

    // Interrupt sources
    input  logic                 instat_tx_set,
    input  logic                 instat_rx_set,

    // Control outputs
    output uart_regs_pkg::baud_t ctrl_baud,
    output logic                 ctrl_txen,
    output logic                 ctrl_rxen,
    output logic                 ctrl_txst,
    output logic [7:0]           lpmode_div,
    output logic                 lpmode_en
);
    import uart_regs_pkg::*;

    ctrl_fields_t fields;

    reg_bus_if i_reg_bus ();

    // ------------------------------
    // Bus side
    // ------------------------------
    axil_write_port i_axil_write_port (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (axil_awaddr),
        .awvalid (axil_awvalid),
        .awready (axil_awready),
        .wdata   (axil_wdata),
        .wstrb   (axil_wstrb),
        .wvalid  (axil_wvalid),
        .wready  (axil_wready),
        .bvalid  (axil_bvalid),
        .bready  (axil_bready),
        .bus     (i_reg_bus.wr_src)
    );

    axil_read_port i_axil_read_port (
        .clk     (clk),
        .rst     (rst),
        .araddr  (axil_araddr),
        .arvalid (axil_arvalid),
        .arready (axil_arready),
        .rdata   (axil_rdata),
        .rvalid  (axil_rvalid),
        .rready  (axil_rready),
        .bus     (i_reg_bus.rd_src)
    );

    // ------------------------------
    // Register logic and read-out
    // ------------------------------
    uart_ctrl_regs i_uart_ctrl_regs (
        .clk           (clk),
        .rst           (rst),
        .txen_set_en   (ctrl_txen_en),
        .txen_in       (ctrl_txen_in),
        .rxen_set_en   (ctrl_rxen_en),
        .rxen_in       (ctrl_rxen_in),
        .instat_tx_set (instat_tx_set),
        .instat_rx_set (instat_rx_set),
        .fields        (fields),
        .ctrl_txst     (ctrl_txst),
        .bus           (i_reg_bus.wr_dst)
    );

    uart_read_decoder i_uart_read_decoder (
        .clk          (clk),
        .rst          (rst),
        .stat_busy_en (stat_busy_en),
        .stat_busy_in (stat_busy_in),
        .stat_rxe_in  (stat_rxe_in),
        .stat_txf_in  (stat_txf_in),
        .fields       (fields),
        .bus          (i_reg_bus.rd_dst)
    );

    // Field unpacking to plain outputs
    assign ctrl_baud  = fields.baud;
    assign ctrl_txen  = fields.txen;
    assign ctrl_rxen  = fields.rxen;
    assign lpmode_div = fields.lpmode_div;
    assign lpmode_en  = fields.lpmode_en;

endmodule

// ==== tb_uart_regs.sv ====
// Testbench with clock, reset, AXI4-Lite tasks, register model, assertions and error summary
module tb_uart_regs;
    timeunit 1ns;
    timeprecision 1ps;
    import uart_regs_pkg::*;

    // Cycles any single wait may take
    localparam int TIMEOUT = 40;

    logic       clk;
    logic       rst;
    addr_t      awaddr;
    logic       awvalid, awready;
    data_t      wdata;
    strb_t      wstrb;
    logic       wvalid, wready;
    logic       bvalid, bready;
    addr_t      araddr;
    logic       arvalid, arready;
    data_t      rdata;
    logic       rvalid, rready;
    logic       stat_busy_en, stat_busy_in, stat_rxe_in, stat_txf_in;
    logic       txen_en, txen_in, rxen_en, rxen_in;
    logic       itx_set, irx_set;
    baud_t      ctrl_baud;
    logic       ctrl_txen, ctrl_rxen, ctrl_txst;
    logic [7:0] lpmode_div;
    logic       lpmode_en;

    // Register model
    baud_t      m_baud;
    logic       m_txen, m_rxen, m_en, m_itx, m_irx, m_busy;
    logic [7:0] m_div;

    int errors = 0;
    int checks = 0;

    uart_regs_top i_uart_regs_top (
        .clk (clk), .rst (rst),
        .axil_awaddr (awaddr), .axil_awvalid (awvalid), .axil_awready (awready),
        .axil_wdata (wdata), .axil_wstrb (wstrb), .axil_wvalid (wvalid),
        .axil_wready (wready), .axil_bvalid (bvalid), .axil_bready (bready),
        .axil_araddr (araddr), .axil_arvalid (arvalid), .axil_arready (arready),
        .axil_rdata (rdata), .axil_rvalid (rvalid), .axil_rready (rready),
        .stat_busy_en (stat_busy_en), .stat_busy_in (stat_busy_in),
        .stat_rxe_in (stat_rxe_in), .stat_txf_in (stat_txf_in),
        .ctrl_txen_en (txen_en), .ctrl_txen_in (txen_in),
        .ctrl_rxen_en (rxen_en), .ctrl_rxen_in (rxen_in),
        .instat_tx_set (itx_set), .instat_rx_set (irx_set),
        .ctrl_baud (ctrl_baud), .ctrl_txen (ctrl_txen), .ctrl_rxen (ctrl_rxen),
        .ctrl_txst (ctrl_txst), .lpmode_div (lpmode_div), .lpmode_en (lpmode_en)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ------------------------------
    // Protocol assertions
    // ------------------------------
    // Pending write response blocks both write channels
    assert property (@(posedge clk) disable iff (rst) bvalid |-> !awready && !wready)
        else begin
            errors++;
            $display("write channel ready during pending response at %0t", $time);
        end
    assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
        else begin
            errors++;
            $display("bvalid dropped without bready at %0t", $time);
        end
    // Read data held stable under back-pressure
    assert property (@(posedge clk) disable iff (rst) rvalid |-> !arready)
        else begin
            errors++;
            $display("arready high during pending read at %0t", $time);
        end
    assert property (@(posedge clk) disable iff (rst)
                     rvalid && !rready |=> rvalid && $stable(rdata))
        else begin
            errors++;
            $display("read data not held without rready at %0t", $time);
        end
    // TXST is one cycle wide and lines up with the first bvalid cycle
    assert property (@(posedge clk) disable iff (rst) ctrl_txst |=> !ctrl_txst)
        else begin
            errors++;
            $display("ctrl_txst longer than one cycle at %0t", $time);
        end
    assert property (@(posedge clk) disable iff (rst) ctrl_txst |-> bvalid && !$past(bvalid))
        else begin
            errors++;
            $display("ctrl_txst outside first bvalid cycle at %0t", $time);
        end

    // ------------------------------
    // Checking helpers
    // ------------------------------
    task automatic finish_run();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    task automatic check_value(input string name, input data_t exp, input data_t act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_timeout(input int cycles, input string what);
        if (cycles >= TIMEOUT) begin
            errors++;
            $display("gave up after %0d cycles waiting for %s", cycles, what);
            finish_run();
        end
    endtask

    function automatic data_t fields_seen();
        return data_t'({ctrl_baud, ctrl_txen, ctrl_rxen, lpmode_div, lpmode_en});
    endfunction

    function automatic data_t fields_model();
        return data_t'({m_baud, m_txen, m_rxen, m_div, m_en});
    endfunction

    // Expected read word from the register map rules
    function automatic data_t expected_word(input addr_t addr);
        data_t w;
        w = '0;
        case (addr)
            ADDR_STAT: begin
                w[STAT_BUSY_BIT] = m_busy;
                w[STAT_RXE_BIT]  = stat_rxe_in;
                w[STAT_TXF_BIT]  = stat_txf_in;
            end
            ADDR_CTRL: begin
                w[1:0]           = m_baud;
                w[CTRL_TXEN_BIT] = m_txen;
                w[CTRL_RXEN_BIT] = m_rxen;
            end
            ADDR_LPMODE: begin
                w[7:0]           = m_div;
                w[LPMODE_EN_BIT] = m_en;
            end
            ADDR_INSTAT: begin
                w[INSTAT_TX_BIT] = m_itx;
                w[INSTAT_RX_BIT] = m_irx;
            end
            ADDR_ID: w = ID_VALUE;
            default: w = '0;
        endcase
        return w;
    endfunction

    // Model update where a held set input beats write-1-clear
    function automatic void apply_write(input addr_t addr, input data_t data, input strb_t strb);
        if (addr == ADDR_CTRL && strb[0]) begin
            m_baud = data[1:0];
            m_txen = data[CTRL_TXEN_BIT];
            m_rxen = data[CTRL_RXEN_BIT];
        end
        if (addr == ADDR_LPMODE && strb[0]) m_div = data[7:0];
        if (addr == ADDR_LPMODE && strb[3]) m_en = data[LPMODE_EN_BIT];
        if (addr == ADDR_INSTAT && strb[0] && data[INSTAT_TX_BIT] && !itx_set) m_itx = 1'b0;
        if (addr == ADDR_INSTAT && strb[0] && data[INSTAT_RX_BIT] && !irx_set) m_irx = 1'b0;
    endfunction

    // ------------------------------
    // AXI4-Lite tasks
    // ------------------------------
    // order 0 both channels together, 1 address first, 2 data first
    task automatic write_reg(input addr_t addr, input data_t data, input strb_t strb,
                             input int order, input int stall);
        int   n;
        logic exp_txst;
        exp_txst = (addr == ADDR_CTRL) && strb[0] && data[CTRL_TXST_BIT];
        awaddr = addr;
        wdata  = data;
        wstrb  = strb;
        awvalid = (order != 2);
        wvalid  = (order != 1);
        for (int phase = 0; phase < ((order == 0) ? 1 : 2); phase++) begin
            if (phase == 1) begin
                // Only the channel still outstanding
                awvalid = (order == 2);
                wvalid  = (order == 1);
            end
            n = 0;
            while ((awvalid && !awready) || (wvalid && !wready)) begin
                @(negedge clk);
                n++;
                check_timeout(n, "write channel ready");
            end
            @(negedge clk);
            awvalid = 1'b0;
            wvalid  = 1'b0;
            // Gap before the second channel
            if (phase == 0 && order != 0) begin
                repeat ($urandom_range(0, 2)) @(negedge clk);
            end
        end
        // Response two edges after the last channel transfer
        n = 0;
        while (!bvalid) begin
            @(negedge clk);
            n++;
            check_timeout(n, "bvalid");
        end
        check_value("write latency", 32'd2, data_t'(n));
        check_value("ctrl_txst", data_t'(exp_txst), data_t'(ctrl_txst));
        apply_write(addr, data, strb);
        check_value("field outputs", fields_model(), fields_seen());
        repeat (stall) @(negedge clk);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic read_check(input addr_t addr, input int stall);
        int    n;
        data_t exp;
        exp     = expected_word(addr);
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        while (!arready) begin
            @(negedge clk);
            n++;
            check_timeout(n, "arready");
        end
        @(negedge clk);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid) begin
            @(negedge clk);
            n++;
            check_timeout(n, "rvalid");
        end
        check_value("read latency", 32'd2, data_t'(n));
        check_value($sformatf("rdata@%h", addr), exp, rdata);
        repeat (stall) @(negedge clk);
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        addr_t a;
        void'($urandom(57846));
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        stat_busy_en = 1'b0;
        stat_busy_in = 1'b0;
        stat_rxe_in = 1'b0;
        stat_txf_in = 1'b0;
        txen_en = 1'b0;
        txen_in = 1'b0;
        rxen_en = 1'b0;
        rxen_in = 1'b0;
        itx_set = 1'b0;
        irx_set = 1'b0;
        m_baud = '0;
        m_txen = 1'b0;
        m_rxen = 1'b0;
        m_div = '0;
        m_en = 1'b0;
        m_itx = 1'b0;
        m_irx = 1'b0;
        m_busy = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // Reset state
        check_value("awready wready arready", 32'h7, data_t'({awready, wready, arready}));
        check_value("bvalid rvalid ctrl_txst", 32'h0, data_t'({bvalid, rvalid, ctrl_txst}));
        check_value("field outputs", 32'h0, fields_seen());
        read_check(ADDR_CTRL, 0);
        read_check(ADDR_LPMODE, 0);
        read_check(ADDR_INSTAT, 0);
        read_check(ADDR_ID, 1);
        read_check(16'h0008, 0);

        // Random writes with random strobes, orders and back-pressure
        for (int i = 0; i < 20; i++) begin
            a = ($urandom_range(0, 1) == 0) ? ADDR_CTRL : ADDR_LPMODE;
            write_reg(a, $urandom(), strb_t'($urandom_range(0, 15)),
                      $urandom_range(0, 2), $urandom_range(0, 3));
            read_check(a, $urandom_range(0, 3));
        end

        // LPMODE.EN only under lane 3
        write_reg(ADDR_LPMODE, 32'h8000_00A5, 4'b0111, 0, 0);
        read_check(ADDR_LPMODE, 0);
        write_reg(ADDR_LPMODE, 32'h8000_0000, 4'b1000, 1, 5);
        read_check(ADDR_LPMODE, 5);

        // TXST pulse only for CTRL bit 6 under lane 0
        write_reg(ADDR_CTRL, 32'h0000_0041, 4'b0001, 2, 1);
        write_reg(ADDR_CTRL, 32'h0000_0040, 4'b1110, 0, 0);
        write_reg(ADDR_LPMODE, 32'h0000_0040, 4'b0001, 0, 0);
        read_check(ADDR_CTRL, 0);

        // INSTAT set then write-0 keeps and write-1 clears
        itx_set = 1'b1;
        @(negedge clk);
        itx_set = 1'b0;
        m_itx = 1'b1;
        read_check(ADDR_INSTAT, 0);
        write_reg(ADDR_INSTAT, 32'h0, 4'hF, 0, 0);
        read_check(ADDR_INSTAT, 0);
        write_reg(ADDR_INSTAT, 32'h1, 4'h1, 1, 0);
        read_check(ADDR_INSTAT, 0);
        // Set held across a clearing write
        irx_set = 1'b1;
        m_irx = 1'b1;
        write_reg(ADDR_INSTAT, 32'h2, 4'h1, 0, 0);
        irx_set = 1'b0;
        read_check(ADDR_INSTAT, 0);
        write_reg(ADDR_INSTAT, 32'h3, 4'h1, 2, 0);
        read_check(ADDR_INSTAT, 0);

        // Hardware enable overwrite visible one edge later
        txen_en = 1'b1;
        txen_in = ~m_txen;
        rxen_en = 1'b1;
        rxen_in = ~m_rxen;
        @(negedge clk);
        m_txen = txen_in;
        m_rxen = rxen_in;
        txen_en = 1'b0;
        rxen_en = 1'b0;
        check_value("field outputs", fields_model(), fields_seen());
        txen_en = 1'b1;
        txen_in = ~m_txen;
        rxen_in = ~m_rxen;
        @(negedge clk);
        m_txen = txen_in;
        txen_en = 1'b0;
        check_value("field outputs", fields_model(), fields_seen());
        read_check(ADDR_CTRL, 0);

        // STAT sampling with BUSY only while enabled
        stat_busy_en = 1'b1;
        stat_busy_in = 1'b1;
        stat_rxe_in = 1'b1;
        stat_txf_in = 1'b0;
        m_busy = 1'b1;
        read_check(ADDR_STAT, 1);
        stat_busy_en = 1'b0;
        stat_busy_in = 1'b0;
        stat_rxe_in = 1'b0;
        stat_txf_in = 1'b1;
        read_check(ADDR_STAT, 0);
        stat_busy_en = 1'b1;
        m_busy = 1'b0;
        read_check(ADDR_STAT, 2);

        finish_run();
    end

endmodule

// ==== flist.f ====
uart_regs_pkg.sv
reg_bus_if.sv
axil_write_port.sv
axil_read_port.sv
uart_ctrl_regs.sv
uart_read_decoder.sv
uart_regs_top.sv
tb_uart_regs.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_uart_regs -f flist.f -o tb_uart_regs > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_uart_regs > sim.log 2>&1
cat sim.log

grep -qx "TEST PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
